//--- source/mem_share_pkg.sv
// shared memory bus package
// bus constants and the port index used between arbiter and response tracker

package mem_share_pkg;

    ////////////////////
    // requester side

    // byte address width, passed unchanged to the memory
    localparam int unsigned ADDR_W    = 32;

    localparam int unsigned WORD_W    = 32;           // requester data width
    localparam int unsigned WORD_BE_W = WORD_W / 8;   // one enable per byte

    ////////////////////
    // port indexing

    // upper bound on the number of requesters, sized to fit port_idx_t
    localparam int unsigned MAX_PORTS = 8;

    // names one requester port
    typedef logic [2:0] port_idx_t;

endpackage

//--- source/lane_port.sv
// lane port that buffers one request of a 32-bit requester, widens it onto the
// memory bus lanes and picks the matching read lane when the response returns
`timescale 1ns/1ns

module lane_port #(
    parameter int unsigned MEM_W = 64
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,

    // requester side
    input  logic                                 req_valid_i,
    input  logic [mem_share_pkg::ADDR_W-1:0]     req_addr_i,
    input  logic                                 req_we_i,
    input  logic [mem_share_pkg::WORD_BE_W-1:0]  req_be_i,
    input  logic [mem_share_pkg::WORD_W-1:0]     req_wdata_i,
    output logic                                 req_ready_o,
    output logic                                 resp_valid_o,
    output logic [mem_share_pkg::WORD_W-1:0]     resp_rdata_o,
    output logic                                 resp_err_o,

    // towards the arbiter
    output logic                                 pend_valid_o,
    output logic [mem_share_pkg::ADDR_W-1:0]     pend_addr_o,
    output logic                                 pend_we_o,
    output logic [MEM_W/8-1:0]                   pend_be_o,
    output logic [MEM_W-1:0]                     pend_wdata_o,
    input  logic                                 port_gnt_i,

    // response path
    input  logic                                 resp_hit_i,
    input  logic [MEM_W-1:0]                     mem_rdata_i,
    input  logic                                 mem_err_i
);

    import mem_share_pkg::*;

    localparam int unsigned BE_W  = MEM_W / 8;
    localparam int unsigned LANES = MEM_W / WORD_W;
    localparam int unsigned OFF_W = $clog2(BE_W);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PEND,
        ST_WAIT
    } state_e;

    state_e            state_q;
    state_e            state_d;
    logic              accept;
    logic [OFF_W-1:0]  off_d;
    logic [OFF_W-1:0]  off_q;     // byte offset of the 32-bit lane
    logic [ADDR_W-1:0] addr_q;
    logic              we_q;
    logic [BE_W-1:0]   be_q;
    logic [MEM_W-1:0]  wdata_q;

    assign accept = req_valid_i & req_ready_o;
    assign off_d  = req_addr_i[OFF_W-1:0] & ~OFF_W'(3);  // drop the byte within the word

    ////////////////////
    // control

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_PEND;
                end
            end
            ST_PEND: begin
                if (port_gnt_i) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (resp_hit_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////
    // request buffer

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q  <= req_addr_i;
            we_q    <= req_we_i;
            be_q    <= BE_W'(req_be_i) << off_d;  // move enables onto the addressed lane
            wdata_q <= {LANES{req_wdata_i}};       // same word on every lane
            off_q   <= off_d;
        end
    end

    assign req_ready_o  = (state_q == ST_IDLE);
    assign pend_valid_o = (state_q == ST_PEND);
    assign pend_addr_o  = addr_q;
    assign pend_we_o    = we_q;
    assign pend_be_o    = be_q;
    assign pend_wdata_o = wdata_q;

    // response leaves in the cycle of the memory rvalid
    assign resp_valid_o = resp_hit_i;
    assign resp_rdata_o = mem_rdata_i[off_q*8 +: WORD_W];
    assign resp_err_o   = resp_hit_i & mem_err_i;

    // the tracker must only route responses to a port that has one outstanding
    no_idle_hit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resp_hit_i |-> state_q == ST_WAIT)
        else $error("lane_port: response routed to a port without an outstanding access");

endmodule

//--- source/grant_select.sv
// grant select picks the highest pending port index by fixed priority
// and puts the winner on the memory bus
`timescale 1ns/1ns

module grant_select #(
    parameter int unsigned MEM_W     = 64,
    parameter int unsigned NUM_PORTS = 3
) (
    input  logic                             pend_valid_i [NUM_PORTS],
    input  logic [mem_share_pkg::ADDR_W-1:0] pend_addr_i  [NUM_PORTS],
    input  logic                             pend_we_i    [NUM_PORTS],
    input  logic [MEM_W/8-1:0]               pend_be_i    [NUM_PORTS],
    input  logic [MEM_W-1:0]                 pend_wdata_i [NUM_PORTS],
    input  logic                             mem_gnt_i,

    output logic                             port_gnt_o   [NUM_PORTS],
    output logic                             grant_fire_o,
    output mem_share_pkg::port_idx_t         grant_idx_o,

    output logic                             mem_req_o,
    output logic [mem_share_pkg::ADDR_W-1:0] mem_addr_o,
    output logic                             mem_we_o,
    output logic [MEM_W/8-1:0]               mem_be_o,
    output logic [MEM_W-1:0]                 mem_wdata_o
);

    import mem_share_pkg::*;

    port_idx_t sel_idx;
    logic      any_pend;

    ////////////////////
    // priority and bus mux

    always_comb begin
        any_pend    = 1'b0;
        sel_idx     = '0;
        mem_addr_o  = '0;
        mem_we_o    = 1'b0;
        mem_be_o    = '0;
        mem_wdata_o = '0;
        // later iterations override earlier ones, so the highest index wins
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (pend_valid_i[i]) begin
                any_pend    = 1'b1;
                sel_idx     = port_idx_t'(i);
                mem_addr_o  = pend_addr_i[i];
                mem_we_o    = pend_we_i[i];
                mem_be_o    = pend_be_i[i];
                mem_wdata_o = pend_wdata_i[i];
            end
        end
    end

    assign mem_req_o    = any_pend;
    assign grant_fire_o = any_pend & mem_gnt_i;  // access transfers this cycle
    assign grant_idx_o  = sel_idx;

    ////////////////////
    // one-hot grant back to the ports

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            port_gnt_o[i] = grant_fire_o && (sel_idx == port_idx_t'(i));
        end
    end

endmodule

//--- source/resp_tracker.sv
// response tracker: remembers which port owns each granted access and steers
// the in-order memory responses back to that port
`timescale 1ns/1ns

module resp_tracker #(
    parameter int unsigned NUM_PORTS = 3
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    input  logic                     grant_fire_i,
    input  mem_share_pkg::port_idx_t grant_idx_i,
    input  logic                     mem_rvalid_i,

    output logic                     resp_hit_o [NUM_PORTS]
);

    import mem_share_pkg::*;

    // one access per port at most, so NUM_PORTS entries always suffice
    localparam int unsigned PTR_W = $clog2(NUM_PORTS);
    localparam int unsigned CNT_W = $clog2(NUM_PORTS + 1);

    port_idx_t        owner_q [NUM_PORTS];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    port_idx_t        head_idx;

    // circular increment, the depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(NUM_PORTS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////
    // queue

    always_ff @(posedge clk_i) begin
        if (grant_fire_i) begin
            owner_q[wr_ptr_q] <= grant_idx_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (grant_fire_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (mem_rvalid_i) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            if (grant_fire_i && !mem_rvalid_i) begin
                count_q <= count_q + 1'b1;
            end else if (!grant_fire_i && mem_rvalid_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    ////////////////////
    // routing

    assign head_idx = owner_q[rd_ptr_q];  // oldest outstanding access

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            resp_hit_o[i] = mem_rvalid_i && (head_idx == port_idx_t'(i));
        end
    end

    no_push_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        grant_fire_i |-> count_q < CNT_W'(NUM_PORTS))
        else $error("resp_tracker: grant while every port already has an access outstanding");

    no_pop_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rvalid_i |-> count_q != '0)
        else $error("resp_tracker: memory response without an outstanding access");

endmodule

//--- source/mem_share_top.sv
// shared memory top: several 32-bit requesters on one wide memory bus,
// fixed-priority arbitration with in-order response routing
`timescale 1ns/1ns

module mem_share_top #(
    parameter int unsigned MEM_W     = 64,  // memory bus width in bits
    parameter int unsigned NUM_PORTS = 3    // number of requesters
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    // requesters
    input  logic                                req_valid_i  [NUM_PORTS],
    input  logic [mem_share_pkg::ADDR_W-1:0]    req_addr_i   [NUM_PORTS],
    input  logic                                req_we_i     [NUM_PORTS],
    input  logic [mem_share_pkg::WORD_BE_W-1:0] req_be_i     [NUM_PORTS],
    input  logic [mem_share_pkg::WORD_W-1:0]    req_wdata_i  [NUM_PORTS],
    output logic                                req_ready_o  [NUM_PORTS],
    output logic                                resp_valid_o [NUM_PORTS],
    output logic [mem_share_pkg::WORD_W-1:0]    resp_rdata_o [NUM_PORTS],
    output logic                                resp_err_o   [NUM_PORTS],

    // memory bus
    output logic                                mem_req_o,
    output logic [mem_share_pkg::ADDR_W-1:0]    mem_addr_o,
    output logic                                mem_we_o,
    output logic [MEM_W/8-1:0]                  mem_be_o,
    output logic [MEM_W-1:0]                    mem_wdata_o,
    input  logic                                mem_gnt_i,
    input  logic                                mem_rvalid_i,
    input  logic                                mem_err_i,
    input  logic [MEM_W-1:0]                    mem_rdata_i
);

    import mem_share_pkg::*;

    if (MEM_W < WORD_W || (MEM_W & (MEM_W - 1)) != 0) begin : g_bad_mem_w
        $fatal(1, "MEM_W must be a power of two of at least 32, got %0d", MEM_W);
    end
    if (NUM_PORTS < 2 || NUM_PORTS > MAX_PORTS) begin : g_bad_num_ports
        $fatal(1, "NUM_PORTS must lie between 2 and %0d, got %0d", MAX_PORTS, NUM_PORTS);
    end

    logic              pend_valid [NUM_PORTS];
    logic [ADDR_W-1:0] pend_addr  [NUM_PORTS];
    logic              pend_we    [NUM_PORTS];
    logic [MEM_W/8-1:0] pend_be   [NUM_PORTS];
    logic [MEM_W-1:0]  pend_wdata [NUM_PORTS];
    logic              port_gnt   [NUM_PORTS];
    logic              resp_hit   [NUM_PORTS];
    logic              grant_fire;
    port_idx_t         grant_idx;

    resp_tracker #(
        .NUM_PORTS    ( NUM_PORTS    )
    ) u_resp_tracker (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .grant_fire_i ( grant_fire   ),
        .grant_idx_i  ( grant_idx    ),
        .mem_rvalid_i ( mem_rvalid_i ),
        .resp_hit_o   ( resp_hit     )
    );

    ////////////////////
    // one adapter per requester

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        lane_port #(
            .MEM_W        ( MEM_W           )
        ) u_lane_port (
            .clk_i        ( clk_i           ),
            .rst_ni       ( rst_ni          ),
            .req_valid_i  ( req_valid_i[i]  ),
            .req_addr_i   ( req_addr_i[i]   ),
            .req_we_i     ( req_we_i[i]     ),
            .req_be_i     ( req_be_i[i]     ),
            .req_wdata_i  ( req_wdata_i[i]  ),
            .req_ready_o  ( req_ready_o[i]  ),
            .resp_valid_o ( resp_valid_o[i] ),
            .resp_rdata_o ( resp_rdata_o[i] ),
            .resp_err_o   ( resp_err_o[i]   ),
            .pend_valid_o ( pend_valid[i]   ),
            .pend_addr_o  ( pend_addr[i]    ),
            .pend_we_o    ( pend_we[i]      ),
            .pend_be_o    ( pend_be[i]      ),
            .pend_wdata_o ( pend_wdata[i]   ),
            .port_gnt_i   ( port_gnt[i]     ),
            .resp_hit_i   ( resp_hit[i]     ),
            .mem_rdata_i  ( mem_rdata_i     ),
            .mem_err_i    ( mem_err_i       )
        );
    end

    grant_select #(
        .MEM_W        ( MEM_W       ),
        .NUM_PORTS    ( NUM_PORTS   )
    ) u_grant_select (
        .pend_valid_i ( pend_valid  ),
        .pend_addr_i  ( pend_addr   ),
        .pend_we_i    ( pend_we     ),
        .pend_be_i    ( pend_be     ),
        .pend_wdata_i ( pend_wdata  ),
        .mem_gnt_i    ( mem_gnt_i   ),
        .port_gnt_o   ( port_gnt    ),
        .grant_fire_o ( grant_fire  ),
        .grant_idx_o  ( grant_idx   ),
        .mem_req_o    ( mem_req_o   ),
        .mem_addr_o   ( mem_addr_o  ),
        .mem_we_o     ( mem_we_o    ),
        .mem_be_o     ( mem_be_o    ),
        .mem_wdata_o  ( mem_wdata_o )
    );

endmodule

//--- bench/mem_model.sv
// memory model: wide byte-enabled memory with random grant stalls,
// in-order responses after 1 to 3 cycles and an error region from 32'h8000_0000
`timescale 1ns/1ns

module mem_model #(
    parameter int unsigned MEM_W = 64
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               mem_req_i,
    input  logic [31:0]        mem_addr_i,
    input  logic               mem_we_i,
    input  logic [MEM_W/8-1:0] mem_be_i,
    input  logic [MEM_W-1:0]   mem_wdata_i,
    output logic               mem_gnt_o,
    output logic               mem_rvalid_o,
    output logic               mem_err_o,
    output logic [MEM_W-1:0]   mem_rdata_o
);

    localparam int unsigned OFF_W = $clog2(MEM_W / 8);

    logic [MEM_W-1:0] words [logic [31:0]];  // keyed by word index
    logic [MEM_W:0]   resp_q [$];            // {err, rdata}
    int unsigned      due_q [$];
    int unsigned      cycle;
    int unsigned      last_due;
    logic [31:0]      lfsr_q;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    // each lane of an unwritten word holds its own byte address, scrambled
    function automatic logic [MEM_W-1:0] fill_word(input logic [31:0] addr);
        logic [MEM_W-1:0] w;
        w = '0;
        for (int l = 0; l < MEM_W / 32; l++) begin
            w[l*32 +: 32] = {addr[31:OFF_W], OFF_W'(l * 4)} ^ 32'h5a5a_0000;
        end
        return w;
    endfunction

    always @(posedge clk_i or negedge rst_ni) begin
        logic [31:0]      key;
        logic [MEM_W-1:0] word;
        logic [MEM_W:0]   resp;
        logic             err;
        int unsigned      due;
        if (!rst_ni) begin
            lfsr_q   = 32'hc1c9;
            cycle    = 0;
            last_due = 0;
            resp_q.delete();
            due_q.delete();
            mem_gnt_o    <= 1'b0;
            mem_rvalid_o <= 1'b0;
            mem_err_o    <= 1'b0;
            mem_rdata_o  <= '0;
        end else begin
            cycle = cycle + 1;
            ////////////////////
            // response side, oldest first
            if (due_q.size() != 0 && due_q[0] == cycle) begin
                resp = resp_q.pop_front();
                void'(due_q.pop_front());
                mem_rvalid_o <= 1'b1;
                mem_err_o    <= resp[MEM_W];
                mem_rdata_o  <= resp[MEM_W-1:0];
            end else begin
                mem_rvalid_o <= 1'b0;
                mem_err_o    <= 1'b0;
            end
            ////////////////////
            // access side
            if (mem_req_i && mem_gnt_o) begin
                key  = mem_addr_i >> OFF_W;
                err  = (mem_addr_i >= 32'h8000_0000);
                word = words.exists(key) ? words[key] : fill_word(mem_addr_i);
                if (!err && mem_we_i) begin
                    for (int b = 0; b < MEM_W / 8; b++) begin
                        if (mem_be_i[b]) word[b*8 +: 8] = mem_wdata_i[b*8 +: 8];
                    end
                    words[key] = word;
                end
                due = cycle + 32'd1 + (lfsr_bits(2) % 32'd3);
                if (due <= last_due) due = last_due + 1;  // one rvalid per cycle
                last_due = due;
                resp_q.push_back({err, word});
                due_q.push_back(due);
            end
            mem_gnt_o <= (lfsr_bits(2) != 32'd0);  // stall about one cycle in four
        end
    end

endmodule

//--- bench/tb_mem_share.sv
// testbench for the shared memory top: directed tests on three requesters
// against the behavioral memory model
`timescale 1ns/1ns

module tb_mem_share;

    import mem_share_pkg::*;

    localparam int unsigned MEM_W     = 64;
    localparam int unsigned NUM_PORTS = 3;
    localparam int          TIMEOUT   = 200;  // cycles per wait

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid  [NUM_PORTS];
    logic [ADDR_W-1:0]    req_addr   [NUM_PORTS];
    logic                 req_we     [NUM_PORTS];
    logic [WORD_BE_W-1:0] req_be     [NUM_PORTS];
    logic [WORD_W-1:0]    req_wdata  [NUM_PORTS];
    logic                 req_ready  [NUM_PORTS];
    logic                 resp_valid [NUM_PORTS];
    logic [WORD_W-1:0]    resp_rdata [NUM_PORTS];
    logic                 resp_err   [NUM_PORTS];
    logic                 mem_req;
    logic [ADDR_W-1:0]    mem_addr;
    logic                 mem_we;
    logic [MEM_W/8-1:0]   mem_be;
    logic [MEM_W-1:0]     mem_wdata;
    logic                 mem_gnt;
    logic                 mem_rvalid;
    logic                 mem_err;
    logic [MEM_W-1:0]     mem_rdata;

    int          errors;
    int          checks;
    int          tests;
    logic [31:0] lfsr_q;

    always #20 clk = ~clk;

    mem_share_top #(
        .MEM_W        ( MEM_W      ),
        .NUM_PORTS    ( NUM_PORTS  )
    ) DUT (
        .clk_i        ( clk        ),
        .rst_ni       ( rst_n      ),
        .req_valid_i  ( req_valid  ),
        .req_addr_i   ( req_addr   ),
        .req_we_i     ( req_we     ),
        .req_be_i     ( req_be     ),
        .req_wdata_i  ( req_wdata  ),
        .req_ready_o  ( req_ready  ),
        .resp_valid_o ( resp_valid ),
        .resp_rdata_o ( resp_rdata ),
        .resp_err_o   ( resp_err   ),
        .mem_req_o    ( mem_req    ),
        .mem_addr_o   ( mem_addr   ),
        .mem_we_o     ( mem_we     ),
        .mem_be_o     ( mem_be     ),
        .mem_wdata_o  ( mem_wdata  ),
        .mem_gnt_i    ( mem_gnt    ),
        .mem_rvalid_i ( mem_rvalid ),
        .mem_err_i    ( mem_err    ),
        .mem_rdata_i  ( mem_rdata  )
    );

    mem_model #(
        .MEM_W        ( MEM_W      )
    ) u_mem (
        .clk_i        ( clk        ),
        .rst_ni       ( rst_n      ),
        .mem_req_i    ( mem_req    ),
        .mem_addr_i   ( mem_addr   ),
        .mem_we_i     ( mem_we     ),
        .mem_be_i     ( mem_be     ),
        .mem_wdata_i  ( mem_wdata  ),
        .mem_gnt_o    ( mem_gnt    ),
        .mem_rvalid_o ( mem_rvalid ),
        .mem_err_o    ( mem_err    ),
        .mem_rdata_o  ( mem_rdata  )
    );

    ////////////////////
    // helpers

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - errs_before);
    endtask

    // one request on port p, returns after its response pulse
    task automatic access(input int p, input logic [31:0] addr, input logic we,
                          input logic [3:0] be, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
        int n;
        rdata        = '0;
        err          = 1'b1;
        req_valid[p] = 1'b1;
        req_addr[p]  = addr;
        req_we[p]    = we;
        req_be[p]    = be;
        req_wdata[p] = wdata;
        n = 0;
        while (!req_ready[p] && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!req_ready[p]) begin
            $display("port %0d never became ready for a request", p);
            errors++;
            req_valid[p] = 1'b0;
            return;
        end
        next_cycle();  // handshake on this edge
        req_valid[p] = 1'b0;
        n = 0;
        while (!resp_valid[p] && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!resp_valid[p]) begin
            $display("port %0d got no response within %0d cycles", p, TIMEOUT);
            errors++;
            return;
        end
        rdata = resp_rdata[p];
        err   = resp_err[p];
        next_cycle();
    endtask

    task automatic write_word(input int p, input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        access(p, addr, 1'b1, be, data, rdata, err);
        check_equal($sformatf("port%0d resp_err_o", p), 32'(err), 32'd0);
    endtask

    task automatic read_expect(input int p, input logic [31:0] addr,
                               input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        access(p, addr, 1'b0, 4'hf, 32'd0, rdata, err);
        check_equal($sformatf("port%0d resp_err_o", p), 32'(err), 32'd0);
        check_equal($sformatf("port%0d resp_rdata_o", p), rdata, exp);
    endtask

    ////////////////////
    // tests

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        for (int c = 0; c < 4; c++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                check_equal($sformatf("port%0d req_ready_o", p), 32'(req_ready[p]), 32'd1);
                check_equal($sformatf("port%0d resp_valid_o", p), 32'(resp_valid[p]), 32'd0);
            end
            next_cycle();
        end
        report_test("reset state", e0);
    endtask

    task automatic test_write_read();
        int e0;
        e0 = errors;
        for (int p = 0; p < NUM_PORTS; p++) begin
            write_word(p, 32'h100 + 32'(p * 8), 4'hf, 32'hc0de_0000 + 32'(p));
            read_expect(p, 32'h100 + 32'(p * 8), 32'hc0de_0000 + 32'(p));
        end
        report_test("write read", e0);
    endtask

    task automatic test_byte_merge();
        int e0;
        e0 = errors;
        write_word(2, 32'h204, 4'hf, 32'ha1b2_c3d4);
        write_word(2, 32'h204, 4'b0101, 32'h5566_7788);
        read_expect(2, 32'h204, 32'ha166_c388);  // bytes 0 and 2 new
        report_test("byte merge", e0);
    endtask

    task automatic test_lane_split();
        int e0;
        e0 = errors;
        write_word(0, 32'h300, 4'hf, 32'h0a0a_0000);
        write_word(1, 32'h304, 4'hf, 32'h1b1b_0004);
        read_expect(1, 32'h300, 32'h0a0a_0000);
        read_expect(0, 32'h304, 32'h1b1b_0004);
        report_test("lane split", e0);
    endtask

    task automatic test_concurrent();
        int          e0;
        logic [31:0] data [NUM_PORTS];
        e0 = errors;
        for (int p = 0; p < NUM_PORTS; p++) data[p] = lfsr_bits(32);
        fork
            write_word(0, 32'h400, 4'hf, data[0]);
            write_word(1, 32'h404, 4'hf, data[1]);
            write_word(2, 32'h408, 4'hf, data[2]);
        join
        fork
            read_expect(0, 32'h400, data[0]);
            read_expect(1, 32'h404, data[1]);
            read_expect(2, 32'h408, data[2]);
        join
        report_test("concurrent", e0);
    endtask

    task automatic test_error_region();
        int          e0;
        logic [31:0] rdata;
        logic        err;
        e0 = errors;
        access(1, 32'h8000_0010, 1'b0, 4'hf, 32'd0, rdata, err);
        check_equal("port1 resp_err_o", 32'(err), 32'd1);
        read_expect(1, 32'h304, 32'h1b1b_0004);  // port recovers
        report_test("error region", e0);
    endtask

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        lfsr_q = 32'hc1c9;
        errors = 0;
        checks = 0;
        tests  = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            req_valid[p] = 1'b0;
            req_addr[p]  = '0;
            req_we[p]    = 1'b0;
            req_be[p]    = '0;
            req_wdata[p] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_state();
        test_write_read();
        test_byte_merge();
        test_lane_split();
        test_concurrent();
        test_error_region();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- tb.f
source/mem_share_pkg.sv
source/lane_port.sv
source/grant_select.sv
source/resp_tracker.sv
source/mem_share_top.sv
bench/mem_model.sv
bench/tb_mem_share.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log for the verdict

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mem_share \
    -f tb.f -o tb_mem_share > build.log 2>&1 \
    && ./obj_dir/tb_mem_share > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "simulation gave no verdict"; exit 1; }
echo "simulation passed"
